// File: verilog/lag_search_config.svh
`ifndef LAG_SEARCH_CONFIG_SVH
`define LAG_SEARCH_CONFIG_SVH

// Scratch memory geometry
`define LS_ADDR_W 12
`define LS_DATA_W 32

// Correlation table, entry for lag_min at the base
`define LS_COR_TABLE_BASE 12'hC00

// Widest lag span the table holds
`define LS_MAX_LAGS 256

`endif

// File: verilog/lag_search_pkg.sv
`include "lag_search_config.svh"

package lag_search_pkg;

	// Sample view of a scratch word
	typedef struct packed {
		logic [15:0]        pad;
		logic signed [15:0] sample;
	} scratch_smp_t;

	// One scratch word, either a table correlation or a signal sample
	typedef union packed {
		logic [`LS_DATA_W-1:0] acc;
		scratch_smp_t          smp;
	} scratch_word_u;

	typedef struct packed {
		logic [`LS_ADDR_W-1:0] waddr;
		scratch_word_u         wdata;
		logic                  we;
	} mem_req_t;

	typedef struct packed {
		logic               clear;
		logic               en;
		logic signed [15:0] a;
		logic signed [15:0] b;
	} mac_op_t;

	typedef struct packed {
		logic [31:0] cor;
		logic [15:0] lag;
	} lag_result_t;

endpackage

// File: verilog/scratch_port_mux.sv
`include "lag_search_config.svh"

module scratch_port_mux (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          host_mode,
	input  lag_search_pkg::mem_req_t      test_req,
	input  logic [`LS_ADDR_W-1:0]         test_raddr,
	input  lag_search_pkg::mem_req_t      eng_req,
	input  logic [`LS_ADDR_W-1:0]         eng_raddr,
	output lag_search_pkg::scratch_word_u read_data
);
	import lag_search_pkg::*;

	localparam int DEPTH = 1 << `LS_ADDR_W;

	scratch_word_u         mem [DEPTH];
	mem_req_t              wr_req;
	logic [`LS_ADDR_W-1:0] rd_addr;

	//////////////////////////////
	// Port selection
	//////////////////////////////

	// Host owns both ports in test mode, the engine otherwise
	always_comb
	begin
		if (host_mode)
		begin
			wr_req  = test_req;
			rd_addr = test_raddr;
		end
		else
		begin
			wr_req  = eng_req;
			rd_addr = eng_raddr;
		end
	end

	//////////////////////////////
	// Scratch RAM
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (wr_req.we)
			mem[wr_req.waddr] <= wr_req.wdata;
	end

	// Registered read, one cycle after the address
	always_ff @(posedge clk)
	begin
		if (rst)
			read_data <= '0;
		else
			read_data <= mem[rd_addr];
	end

endmodule

// File: verilog/sat_mac.sv
module sat_mac (
	input  logic                    clk,
	input  logic                    rst,
	input  lag_search_pkg::mac_op_t op,
	output logic signed [31:0]      acc
);
	localparam logic [15:0] MIN_16 = 16'h8000;
	localparam logic signed [31:0] MAX_32 = 32'sh7fff_ffff;
	localparam logic signed [31:0] MIN_32 = 32'sh8000_0000;

	logic signed [31:0] raw;
	logic signed [31:0] prod;
	logic signed [32:0] sum;
	logic signed [31:0] sum_sat;

	// L_mult, doubled product with the one overflow case pinned
	always_comb
	begin
		raw = op.a * op.b;
		if (op.a == MIN_16 && op.b == MIN_16)
			prod = MAX_32;
		else
			prod = raw <<< 1;
	end

	// L_add on one extra bit, clamp when the top two bits split
	always_comb
	begin
		sum = {acc[31], acc} + {prod[31], prod};
		if (sum[32] != sum[31])
			sum_sat = sum[32] ? MIN_32 : MAX_32;
		else
			sum_sat = sum[31:0];
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			acc <= '0;
		else if (op.clear)
			acc <= prod;
		else if (op.en)
			acc <= sum_sat;
	end

endmodule

// File: verilog/lag_search_fsm.sv
`include "lag_search_config.svh"

module lag_search_fsm (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          start,
	input  logic [`LS_ADDR_W-1:0]         signal,
	input  logic [15:0]                   L_frame,
	input  logic [15:0]                   lag_max,
	input  logic [15:0]                   lag_min,
	input  lag_search_pkg::scratch_word_u read_data,
	input  logic signed [31:0]            acc,
	output lag_search_pkg::mem_req_t      eng_req,
	output logic [`LS_ADDR_W-1:0]         eng_raddr,
	output lag_search_pkg::mac_op_t       mac_op,
	output lag_search_pkg::lag_result_t   best,
	output logic                          found
);
	import lag_search_pkg::*;

	localparam int OFF_W = $clog2(`LS_MAX_LAGS);

	localparam logic [2:0] S_IDLE   = 3'd0;
	localparam logic [2:0] S_RD_CUR = 3'd1;
	localparam logic [2:0] S_RD_LAG = 3'd2;
	localparam logic [2:0] S_TAIL   = 3'd3;
	localparam logic [2:0] S_WB     = 3'd4;

	logic [2:0]            state;
	logic [15:0]           lag;
	logic [15:0]           j;
	logic                  pend;
	logic                  first;
	logic [`LS_ADDR_W-1:0] sig_r;
	logic [15:0]           len_r;
	logic [15:0]           lmin_r;
	logic signed [15:0]    opa;
	logic [OFF_W-1:0]      tab_off;

	//////////////////////////////
	// Addresses and MAC feed
	//////////////////////////////

	// x[signal+j] first, then x[signal+j-lag]
	always_comb
	begin
		if (state == S_RD_LAG)
			eng_raddr = sig_r + j[`LS_ADDR_W-1:0] - lag[`LS_ADDR_W-1:0];
		else
			eng_raddr = sig_r + j[`LS_ADDR_W-1:0];
	end

	// Second operand arrives the cycle after S_RD_LAG
	always_comb
	begin
		mac_op.clear = pend && first;
		mac_op.en    = pend && !first;
		mac_op.a     = opa;
		mac_op.b     = read_data.smp.sample;
	end

	// Table write-back once the last product has landed
	always_comb
	begin
		tab_off           = OFF_W'(lag - lmin_r);
		eng_req.we        = (state == S_WB);
		eng_req.waddr     = `LS_COR_TABLE_BASE + `LS_ADDR_W'(tab_off);
		eng_req.wdata.acc = acc;
	end

	//////////////////////////////
	// Control
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= S_IDLE;
			lag   <= '0;
			j     <= '0;
			pend  <= 1'b0;
			first <= 1'b0;
			found <= 1'b0;
			best  <= '0;
		end
		else
		begin
			pend  <= (state == S_RD_LAG);
			found <= 1'b0;
			if (mac_op.clear)
				first <= 1'b0;
			case (state)
				S_IDLE:
				begin
					if (start)
					begin
						lag      <= lag_max;
						j        <= '0;
						first    <= 1'b1;
						// Most negative value, so the first lag always wins
						best.cor <= 32'h8000_0000;
						best.lag <= lag_max;
						state    <= S_RD_CUR;
					end
				end
				S_RD_CUR:
					state <= S_RD_LAG;
				S_RD_LAG:
				begin
					j <= j + 16'd1;
					if (j == len_r - 16'd1)
						state <= S_TAIL;
					else
						state <= S_RD_CUR;
				end
				S_TAIL:
					state <= S_WB;
				S_WB:
				begin
					// Greater or equal, lower lags take ties
					if (acc >= $signed(best.cor))
					begin
						best.cor <= acc;
						best.lag <= lag;
					end
					j <= '0;
					if (lag == lmin_r)
					begin
						found <= 1'b1;
						state <= S_IDLE;
					end
					else
					begin
						lag   <= lag - 16'd1;
						first <= 1'b1;
						state <= S_RD_CUR;
					end
				end
				default:
					state <= S_IDLE;
			endcase
		end
	end

	// Run parameters and first operand
	always_ff @(posedge clk)
	begin
		if (state == S_IDLE && start)
		begin
			sig_r  <= signal;
			len_r  <= L_frame;
			lmin_r <= lag_min;
		end
		if (state == S_RD_LAG)
			opa <= read_data.smp.sample;
	end

endmodule

// File: verilog/cor_normalizer.sv
module cor_normalizer (
	input  logic                        clk,
	input  logic                        rst,
	input  lag_search_pkg::lag_result_t best,
	input  logic                        found,
	output logic [15:0]                 cor_max,
	output logic [15:0]                 p_max,
	output logic                        done
);
	logic        busy;
	logic [31:0] val;
	logic [15:0] lag_r;
	logic [4:0]  cnt;
	logic        norm_ok;

	// Stop on sign change below bit 31, zero, or a full 31 shifts
	always_comb
	begin
		norm_ok = (val == 32'd0) || (val[31] != val[30]) || (cnt == 5'd31);
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			busy    <= 1'b0;
			done    <= 1'b0;
			cor_max <= '0;
			p_max   <= '0;
			cnt     <= '0;
		end
		else
		begin
			done <= 1'b0;
			if (found && !busy)
			begin
				busy <= 1'b1;
				cnt  <= '0;
			end
			else if (busy)
			begin
				if (norm_ok)
				begin
					// Results hold until the next done
					busy    <= 1'b0;
					done    <= 1'b1;
					cor_max <= val[31:16];
					p_max   <= lag_r;
				end
				else
					cnt <= cnt + 5'd1;
			end
		end
	end

	// Working value, one left shift per cycle
	always_ff @(posedge clk)
	begin
		if (found && !busy)
		begin
			val   <= best.cor;
			lag_r <= best.lag;
		end
		else if (busy && !norm_ok)
			val <= val << 1;
	end

endmodule

// File: verilog/lag_search.sv
`include "lag_search_config.svh"

module lag_search (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          start,
	input  logic                          host_mode,
	input  lag_search_pkg::mem_req_t      test_req,
	input  logic [`LS_ADDR_W-1:0]         test_raddr,
	input  logic [`LS_ADDR_W-1:0]         signal,
	input  logic [15:0]                   L_frame,
	input  logic [15:0]                   lag_max,
	input  logic [15:0]                   lag_min,
	output lag_search_pkg::scratch_word_u read_data,
	output logic [15:0]                   cor_max,
	output logic [15:0]                   p_max,
	output logic                          done
);
	import lag_search_pkg::*;

	mem_req_t              eng_req;
	logic [`LS_ADDR_W-1:0] eng_raddr;
	mac_op_t               mac_op;
	logic signed [31:0]    acc;
	lag_result_t           best;
	logic                  found;

	// Scratch RAM shared by host and engine
	scratch_port_mux u_scratch_port_mux (
		.clk        (clk),
		.rst        (rst),
		.host_mode  (host_mode),
		.test_req   (test_req),
		.test_raddr (test_raddr),
		.eng_req    (eng_req),
		.eng_raddr  (eng_raddr),
		.read_data  (read_data)
	);

	lag_search_fsm u_lag_search_fsm (
		.clk       (clk),
		.rst       (rst),
		.start     (start),
		.signal    (signal),
		.L_frame   (L_frame),
		.lag_max   (lag_max),
		.lag_min   (lag_min),
		.read_data (read_data),
		.acc       (acc),
		.eng_req   (eng_req),
		.eng_raddr (eng_raddr),
		.mac_op    (mac_op),
		.best      (best),
		.found     (found)
	);

	sat_mac u_sat_mac (
		.clk (clk),
		.rst (rst),
		.op  (mac_op),
		.acc (acc)
	);

	cor_normalizer u_cor_normalizer (
		.clk     (clk),
		.rst     (rst),
		.best    (best),
		.found   (found),
		.cor_max (cor_max),
		.p_max   (p_max),
		.done    (done)
	);

endmodule

// File: verif/lag_search_asserts.sv
module lag_search_asserts (
	input logic clk,
	input logic rst,
	input logic host_mode,
	input logic eng_we,
	input logic done
);

	// Failed assertions so far
	int fail_count = 0;

	// A done pulse never stretches
	property done_one_cycle;
		@(posedge clk) disable iff (rst)
			done |=> !done;
	endproperty

	// Engine keeps off the RAM while the host owns it
	property no_engine_write_in_host_mode;
		@(posedge clk) disable iff (rst)
			host_mode |-> !eng_we;
	endproperty

	property done_low_after_reset;
		@(posedge clk)
			rst |=> !done;
	endproperty

	a_done_one_cycle: assert property (done_one_cycle)
		else
		begin
			$error("done stayed high for more than one cycle");
			fail_count++;
		end

	a_no_engine_write: assert property (no_engine_write_in_host_mode)
		else
		begin
			$error("engine write while host_mode is high");
			fail_count++;
		end

	a_done_after_reset: assert property (done_low_after_reset)
		else
		begin
			$error("done high in the cycle after reset");
			fail_count++;
		end

endmodule

// File: verif/lag_search_tb.sv
`include "lag_search_config.svh"

module lag_search_tb;
	import lag_search_pkg::*;

	localparam int SIG_BASE   = 256;
	localparam int FRAME      = 40;
	localparam int SIG_RAMP   = 0;
	localparam int SIG_RANDOM = 1;
	localparam int SIG_FULL   = 2;
	localparam int SIG_ZERO   = 3;
	localparam longint MAX32  = 64'sd2147483647;
	localparam longint MIN32  = -64'sd2147483648;

	// Worst case from start to done for one run
	function automatic int run_bound(input int lags, input int len);
		return lags * (2 * len + 4) + 40;
	endfunction

	// Three short runs, one long run, host traffic on top
	localparam int TIMEOUT_CYCLES = 3 * run_bound(21, FRAME) + run_bound(124, FRAME) + 3000;

	logic          clk = 1'b0;
	logic          rst;
	logic          start;
	logic          host_mode;
	mem_req_t      test_req;
	logic [11:0]   test_raddr;
	logic [11:0]   signal;
	logic [15:0]   L_frame;
	logic [15:0]   lag_max;
	logic [15:0]   lag_min;
	scratch_word_u read_data;
	logic [15:0]   cor_max;
	logic [15:0]   p_max;
	logic          done;

	logic signed [15:0] model_x [1 << `LS_ADDR_W];
	int                 model_cor [`LS_MAX_LAGS];
	logic [31:0]        lfsr;
	int                 errors = 0;
	int                 tests = 0;
	int                 failed_tests = 0;
	int                 cycle_count = 0;
	int                 assert_seen = 0;

	lag_search u_lag_search (
		.clk        (clk),
		.rst        (rst),
		.start      (start),
		.host_mode  (host_mode),
		.test_req   (test_req),
		.test_raddr (test_raddr),
		.signal     (signal),
		.L_frame    (L_frame),
		.lag_max    (lag_max),
		.lag_min    (lag_min),
		.read_data  (read_data),
		.cor_max    (cor_max),
		.p_max      (p_max),
		.done       (done)
	);

	bind lag_search lag_search_asserts u_lag_search_asserts (
		.clk       (clk),
		.rst       (rst),
		.host_mode (host_mode),
		.eng_we    (eng_req.we),
		.done      (done)
	);

	always #10 clk = ~clk;

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES)
		begin
			$display("timeout: the run went past %0d clock cycles", TIMEOUT_CYCLES);
			$display("Regression failed");
			$finish;
		end
	end

	//////////////////////////////
	// Stimulus and reference model
	//////////////////////////////

	// Galois step, polynomial x^32+x^22+x^2+x+1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		else
			return s >> 1;
	endfunction

	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int k = 0; k < n; k++)
		begin
			v = {v[14:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
		return v;
	endfunction

	function automatic int sat32(input longint v);
		if (v > MAX32)
			return int'(MAX32);
		else if (v < MIN32)
			return int'(MIN32);
		else
			return int'(v);
	endfunction

	function automatic int l_mult(input logic signed [15:0] a, input logic signed [15:0] b);
		return sat32(2 * longint'(a) * longint'(b));
	endfunction

	function automatic int l_add(input int a, input int b);
		return sat32(longint'(a) + longint'(b));
	endfunction

	// Every lag's correlation, the winner and its normalized upper half
	function automatic void model_search(input int sig, input int len, input int lmax,
		input int lmin, output logic [15:0] exp_cor, output logic [15:0] exp_lag);
		int          cor;
		int          best_cor;
		int          best_lag;
		logic [31:0] norm;
		best_cor = 0;
		best_lag = lmax;
		for (int i = lmax; i >= lmin; i--)
		begin
			cor = 0;
			for (int j = 0; j < len; j++)
				cor = l_add(cor, l_mult(model_x[12'(sig + j)], model_x[12'(sig + j - i)]));
			model_cor[8'(i - lmin)] = cor;
			// Ties go to the smaller lag
			if (i == lmax || cor >= best_cor)
			begin
				best_cor = cor;
				best_lag = i;
			end
		end
		norm = best_cor;
		for (int k = 0; k < 31 && norm != 0 && norm[31] == norm[30]; k++)
			norm = norm << 1;
		exp_cor = norm[31:16];
		exp_lag = 16'(best_lag);
	endfunction

	//////////////////////////////
	// Host port and run helpers
	//////////////////////////////

	task automatic report_mismatch(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		errors++;
		$display("error @%0t: %s got %h expected %h", $time, what, got, exp);
	endtask

	task automatic finish_test(input string name, input int err_before);
		int assert_new;
		// Bound assertion failures count against the test that saw them
		assert_new  = u_lag_search.u_lag_search_asserts.fail_count - assert_seen;
		assert_seen = assert_seen + assert_new;
		errors      = errors + assert_new;
		tests++;
		if (errors == err_before)
			$display("test %s: ok", name);
		else
		begin
			failed_tests++;
			$display("test %s: %0d errors", name, errors - err_before);
		end
	endtask

	task automatic write_word(input logic [11:0] addr, input scratch_word_u w);
		mem_req_t r;
		r.waddr = addr;
		r.wdata = w;
		r.we    = 1'b1;
		@(posedge clk);
		test_req <= r;
	endtask

	// Last write lands on this edge
	task automatic end_writes();
		@(posedge clk);
		test_req <= '0;
	endtask

	task automatic read_word(input logic [11:0] addr, output scratch_word_u w);
		@(posedge clk);
		test_raddr <= addr;
		@(posedge clk);
		@(negedge clk);
		w = read_data;
	endtask

	// Samples from signal-lmax up to signal+len-1
	task automatic load_signal(input int kind, input int sig, input int len, input int lmax);
		logic signed [15:0] s;
		logic [15:0]        r;
		scratch_word_u      w;
		@(posedge clk);
		host_mode <= 1'b1;
		for (int a = sig - lmax; a < sig + len; a++)
		begin
			case (kind)
				SIG_RAMP:
					s = 16'((a - sig) * 50);
				SIG_RANDOM:
				begin
					r = rand_bits(12);
					s = {{4{r[11]}}, r[11:0]};
				end
				SIG_FULL:
					s = 16'sh8000;
				default:
					s = '0;
			endcase
			w.smp.pad    = '0;
			w.smp.sample = s;
			model_x[12'(a)] = s;
			write_word(12'(a), w);
		end
		end_writes();
	endtask

	task automatic run_search(input int sig, input int len, input int lmax, input int lmin);
		logic [15:0] exp_cor;
		logic [15:0] exp_lag;
		int          bound;
		int          waited;
		model_search(sig, len, lmax, lmin, exp_cor, exp_lag);
		bound  = run_bound(lmax - lmin + 1, len);
		waited = 0;
		@(posedge clk);
		host_mode <= 1'b0;
		signal    <= 12'(sig);
		L_frame   <= 16'(len);
		lag_max   <= 16'(lmax);
		lag_min   <= 16'(lmin);
		start     <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		while (done !== 1'b1 && waited < bound)
		begin
			@(negedge clk);
			waited++;
		end
		if (done !== 1'b1)
		begin
			errors++;
			$display("done did not arrive within %0d cycles of start", bound);
		end
		else
		begin
			if (cor_max !== exp_cor)
				report_mismatch("cor_max", {16'h0, cor_max}, {16'h0, exp_cor});
			if (p_max !== exp_lag)
				report_mismatch("p_max", {16'h0, p_max}, {16'h0, exp_lag});
		end
	endtask

	//////////////////////////////
	// Directed tests
	//////////////////////////////

	task automatic test_host_port();
		int            err_before;
		logic [11:0]   addr;
		scratch_word_u w;
		scratch_word_u rd;
		err_before = errors;
		@(posedge clk);
		host_mode <= 1'b1;
		for (int k = 0; k < 6; k++)
		begin
			addr  = 12'(k * 683 + 5);
			w.acc = {addr, 4'h9, ~addr, 4'h3};
			write_word(addr, w);
		end
		end_writes();
		for (int k = 0; k < 6; k++)
		begin
			addr  = 12'(k * 683 + 5);
			w.acc = {addr, 4'h9, ~addr, 4'h3};
			read_word(addr, rd);
			if (rd.acc !== w.acc)
				report_mismatch("acc view", rd.acc, w.acc);
			if (rd.smp.sample !== w.acc[15:0])
				report_mismatch("sample view", {16'h0, rd.smp.sample}, {16'h0, w.acc[15:0]});
			if (rd.smp.pad !== w.acc[31:16])
				report_mismatch("pad view", {16'h0, rd.smp.pad}, {16'h0, w.acc[31:16]});
		end
		finish_test("host_port", err_before);
	endtask

	task automatic test_ramp();
		int err_before;
		err_before = errors;
		load_signal(SIG_RAMP, SIG_BASE, FRAME, 40);
		run_search(SIG_BASE, FRAME, 40, 20);
		finish_test("ramp", err_before);
	endtask

	task automatic test_random();
		int err_before;
		err_before = errors;
		load_signal(SIG_RANDOM, SIG_BASE, FRAME, 143);
		run_search(SIG_BASE, FRAME, 143, 20);
		finish_test("random", err_before);
	endtask

	// Table left behind by the random run
	task automatic test_table();
		int            err_before;
		scratch_word_u rd;
		err_before = errors;
		@(posedge clk);
		host_mode <= 1'b1;
		for (int i = 0; i <= 143 - 20; i++)
		begin
			read_word(12'(`LS_COR_TABLE_BASE + i), rd);
			if (rd.acc !== model_cor[8'(i)])
				report_mismatch("table entry", rd.acc, model_cor[8'(i)]);
		end
		finish_test("table", err_before);
	endtask

	task automatic test_saturation();
		int err_before;
		err_before = errors;
		load_signal(SIG_FULL, SIG_BASE, FRAME, 40);
		run_search(SIG_BASE, FRAME, 40, 20);
		if (cor_max !== 16'h7fff)
			report_mismatch("full-scale cor_max", {16'h0, cor_max}, 32'h7fff);
		if (p_max !== 16'd20)
			report_mismatch("full-scale p_max", {16'h0, p_max}, 32'd20);
		// All-zero frame normalizes to zero
		load_signal(SIG_ZERO, SIG_BASE, FRAME, 40);
		run_search(SIG_BASE, FRAME, 40, 20);
		if (cor_max !== 16'h0000)
			report_mismatch("zero cor_max", {16'h0, cor_max}, 32'h0);
		if (p_max !== 16'd20)
			report_mismatch("zero p_max", {16'h0, p_max}, 32'd20);
		finish_test("saturation", err_before);
	endtask

	initial
	begin
		rst        <= 1'b1;
		start      <= 1'b0;
		host_mode  <= 1'b0;
		test_req   <= '0;
		test_raddr <= '0;
		signal     <= '0;
		L_frame    <= '0;
		lag_max    <= '0;
		lag_min    <= '0;
		lfsr = 32'hf2ae_0d43;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		test_host_port();
		test_ramp();
		test_random();
		test_table();
		test_saturation();
		$display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// File: lag_search.f
+incdir+verilog
verilog/lag_search_pkg.sv
verilog/scratch_port_mux.sv
verilog/sat_mac.sv
verilog/lag_search_fsm.sv
verilog/cor_normalizer.sv
verilog/lag_search.sv
verif/lag_search_asserts.sv
verif/lag_search_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= lag_search_tb
RTL_TOP   ?= lag_search
FLIST     ?= lag_search.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Regression passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
